// ==== memset.f ====
rtl/memset_pkg.sv
rtl/single_port_ram.sv
rtl/memory_controller.sv
rtl/memset_engine.sv
rtl/memset_top.sv
testbench/clock_gen.sv
testbench/memset_tb.sv

// ==== rtl/memory_controller.sv ====
`timescale 1ns/1ps

module memory_controller (
	input  logic                          clk,
	input  logic                          reset,
	input  memset_pkg::mem_req_t          wr_req,
	input  logic                          rd_en,
	input  logic [memset_pkg::addr_w-1:0] rd_addr,
	input  logic [memset_pkg::data_w-1:0] ram_out,
	output memset_pkg::mem_req_t          ram_req,
	output logic                          rd_valid,
	output logic [memset_pkg::data_w-1:0] rd_data
);
	import memset_pkg::*;

	mem_req_t rd_req;   // Host read mapped onto the RAM port.
	logic     rd_issue; // Host read actually reaches the RAM.

	// Engine writes have fixed priority over host reads.
	// A read that collides with a write is lost.
	assign rd_issue = rd_en && !wr_req.we;

	always_comb
	begin
		rd_req.we   = 1'b0;
		rd_req.addr = rd_addr;
		rd_req.data = '0;
	end

	// Port mux.
	always_comb
	begin
		if (wr_req.we)
		begin
			ram_req = wr_req;
		end
		else
		begin
			ram_req = rd_req; // Idle cycles also read, harmlessly.
		end
	end

	// The RAM output register lines up with this flag one cycle after
	// the read is issued.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_valid <= 1'b0;
		end
		else
		begin
			rd_valid <= rd_issue;
		end
	end

	assign rd_data = ram_out; // Registered inside the RAM.

endmodule

// ==== rtl/memset_engine.sv ====
`timescale 1ns/1ps

module memset_engine (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          start,
	input  logic [memset_pkg::addr_w-1:0] m,
	input  logic [memset_pkg::data_w-1:0] c,
	input  logic [memset_pkg::len_w-1:0]  n,
	output memset_pkg::mem_req_t          wr_req,
	output logic                          finish,
	output logic                          busy,
	output logic [memset_pkg::addr_w-1:0] return_val
);
	import memset_pkg::*;

	engine_state_t state;
	engine_state_t state_next;

	logic [addr_w-1:0] base_addr; // Start address of the running command.
	logic [addr_w-1:0] cur_addr;  // Address of the write being presented.
	logic [data_w-1:0] fill_byte; // Byte written to every location.
	logic [len_w-1:0]  remaining; // Writes still to go, including the current one.

	logic start_ok;   // Start accepted in this cycle.
	logic empty_cmd;  // Command with a length of zero.
	logic last_write; // Final write of the fill is presented.

	// Start only counts while the engine is idle.
	assign start_ok   = start && (state == st_idle);
	assign empty_cmd  = (n == '0);
	assign last_write = (state == st_fill) && (remaining == len_w'(1));

	// Next state.
	always_comb
	begin
		state_next = state;
		case (state)
			st_idle:
			begin
				if (start_ok)
				begin
					// A zero length skips the fill entirely.
					state_next = empty_cmd ? st_done : st_fill;
				end
			end
			st_fill:
			begin
				if (last_write)
				begin
					state_next = st_done;
				end
			end
			st_done:
			begin
				state_next = st_idle; // Done lasts exactly one cycle.
			end
			default:
			begin
				state_next = st_idle;
			end
		endcase
	end

	// State register.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
		end
		else
		begin
			state <= state_next;
		end
	end

	// Remaining count.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			remaining <= '0;
		end
		else if (start_ok)
		begin
			remaining <= n;
		end
		else if (state == st_fill)
		begin
			remaining <= remaining - len_w'(1);
		end
	end

	// Command fields and running address.
	always_ff @(posedge clk)
	begin
		if (start_ok)
		begin
			base_addr <= m;
			cur_addr  <= m;
			fill_byte <= c;
		end
		else if (state == st_fill)
		begin
			cur_addr <= cur_addr + addr_w'(1); // Wraps past the top word.
		end
	end

	// The result is loaded on entry to st_done so that it is already
	// valid during the finish pulse.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			return_val <= '0;
		end
		else if (start_ok && empty_cmd)
		begin
			return_val <= m;
		end
		else if (last_write)
		begin
			return_val <= base_addr;
		end
	end

	// Write request toward the controller.
	always_comb
	begin
		wr_req.we   = (state == st_fill);
		wr_req.addr = cur_addr;
		wr_req.data = fill_byte;
	end

	assign finish = (state == st_done);
	assign busy   = (state != st_idle); // High from the cycle after start to finish.

endmodule

// ==== rtl/memset_pkg.sv ====
package memset_pkg;

	// RAM geometry.
	localparam int addr_w = 5;  // Address width of the 32 word RAM.
	localparam int data_w = 8;  // Word width, also the fill byte width.
	localparam int depth  = 32; // Number of RAM locations.

	// Length needs one more bit than the address so that a full fill of
	// all 32 locations can be requested.
	localparam int len_w = 6;

	// One request to the single RAM port.
	// A low we turns the request into a read of addr.
	typedef struct packed {
		logic              we;   // Write strobe.
		logic [addr_w-1:0] addr; // Word address.
		logic [data_w-1:0] data; // Write data, ignored on reads.
	} mem_req_t;

	// Fill engine states.
	typedef enum logic [1:0] {
		st_idle = 2'd0, // Waiting for start.
		st_fill = 2'd1, // One write per cycle.
		st_done = 2'd2  // Finish pulse.
	} engine_state_t;

endpackage

// ==== rtl/memset_top.sv ====
`timescale 1ns/1ps

module memset_top (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          start,
	input  logic [memset_pkg::addr_w-1:0] m,
	input  logic [memset_pkg::data_w-1:0] c,
	input  logic [memset_pkg::len_w-1:0]  n,
	input  logic                          rd_en,
	input  logic [memset_pkg::addr_w-1:0] rd_addr,
	output logic                          finish,
	output logic                          busy,
	output logic [memset_pkg::addr_w-1:0] return_val,
	output logic                          rd_valid,
	output logic [memset_pkg::data_w-1:0] rd_data
);
	import memset_pkg::*;

	mem_req_t          wr_req;  // Engine write stream.
	mem_req_t          ram_req; // Arbitrated RAM port.
	logic [data_w-1:0] ram_out; // Registered RAM read data.

	// Fill engine.
	memset_engine u_engine (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.m          (m),
		.c          (c),
		.n          (n),
		.wr_req     (wr_req),
		.finish     (finish),
		.busy       (busy),
		.return_val (return_val)
	);

	// Port arbiter and read valid tracking.
	memory_controller u_ctrl (
		.clk      (clk),
		.reset    (reset),
		.wr_req   (wr_req),
		.rd_en    (rd_en),
		.rd_addr  (rd_addr),
		.ram_out  (ram_out),
		.ram_req  (ram_req),
		.rd_valid (rd_valid),
		.rd_data  (rd_data)
	);

	// 32 x 8 storage.
	single_port_ram u_ram (
		.clk (clk),
		.req (ram_req),
		.out (ram_out)
	);

endmodule

// ==== rtl/single_port_ram.sv ====
`timescale 1ns/1ps

module single_port_ram (
	input  logic                          clk,
	input  memset_pkg::mem_req_t          req,
	output logic [memset_pkg::data_w-1:0] out
);
	import memset_pkg::*;

	logic [data_w-1:0] mem [depth]; // Storage array.
	logic [data_w-1:0] rd_word;     // Registered read word.

	// A write updates the array on the edge.
	// Any other cycle captures the addressed word.
	always_ff @(posedge clk)
	begin
		if (req.we)
		begin
			mem[req.addr] <= req.data;
		end
		else
		begin
			rd_word <= mem[req.addr];
		end
	end

	assign out = rd_word;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the memset testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module memset_tb -f memset.f -o memset_sim

./obj_dir/memset_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi

if ! grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

echo "simulation passed"

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
	output logic clk,
	output logic reset
);

	// 40 ns period.
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reset covers four rising edges and drops on a falling edge.
	initial
	begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== testbench/memset_tb.sv ====
`timescale 1ns/1ps

module memset_tb;
	import memset_pkg::*;

	localparam int planned_ops   = 50;  // 25 fills and 25 full read-backs.
	localparam int cycles_per_op = 200;
	localparam int clk_period_ns = 40;
	localparam int watchdog_ns   = (planned_ops * cycles_per_op + 500) * clk_period_ns;

	logic              clk;
	logic              reset;
	logic              start;
	logic [addr_w-1:0] m;
	logic [data_w-1:0] c;
	logic [len_w-1:0]  n;
	logic              rd_en;
	logic [addr_w-1:0] rd_addr;
	logic              finish;
	logic              busy;
	logic [addr_w-1:0] return_val;
	logic              rd_valid;
	logic [data_w-1:0] rd_data;

	logic              rd_expect = 1'b0;   // The read now driven should be served.
	logic              valid_due = 1'b0;   // A served read returns at this edge.
	logic [data_w-1:0] shadow [depth];     // Model of the RAM contents.
	logic [data_w-1:0] exp_q [$];          // Expected bytes of reads in flight.
	logic [addr_w-1:0] last_ret = '0;      // Value return_val should hold.
	int unsigned       lcg_state = 31479;

	clock_gen u_clk (
		.clk   (clk),
		.reset (reset)
	);

	memset_top UUT (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.m          (m),
		.c          (c),
		.n          (n),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.finish     (finish),
		.busy       (busy),
		.return_val (return_val),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data)
	);

	task abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task check_data(input string name, input logic [data_w-1:0] got,
		input logic [data_w-1:0] expected);
		if (got !== expected)
		begin
			abort_run($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, name, got, expected));
		end
	endtask

	task check_addr(input string name, input logic [addr_w-1:0] got,
		input logic [addr_w-1:0] expected);
		if (got !== expected)
		begin
			abort_run($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, name, got, expected));
		end
	endtask

	task check_flag(input string name, input logic got, input logic expected);
		if (got !== expected)
		begin
			abort_run($sformatf("mismatch at %0t: %s got %b expected %b",
				$time, name, got, expected));
		end
	endtask

	function int unsigned next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16; // Upper bits have the longer period.
	endfunction

	// Writes n bytes of c from m upward.
	function void ref_fill(input logic [addr_w-1:0] m_v, input logic [data_w-1:0] c_v,
		input logic [len_w-1:0] n_v);
		logic [addr_w-1:0] a;
		for (int i = 0; i < int'(n_v); i++)
		begin
			a = addr_w'((int'(m_v) + i) % depth); // Wraps modulo the depth.
			shadow[a] = c_v;
		end
	endfunction

	function logic [data_w-1:0] ref_read(input logic [addr_w-1:0] a);
		return shadow[a];
	endfunction

	// Every served read must come back exactly one edge later.
	always @(posedge clk)
	begin : read_compare
		logic [data_w-1:0] expected;
		if (reset)
		begin
			valid_due = 1'b0;
		end
		else
		begin
			check_flag("rd_valid", rd_valid, valid_due);
			if (valid_due)
			begin
				expected = exp_q.pop_front();
				check_data("rd_data", rd_data, expected);
			end
			valid_due = rd_en && rd_expect;
		end
	end

	// One command with its cycle-by-cycle busy, finish and return_val checks.
	task run_fill(input logic [addr_w-1:0] m_v, input logic [data_w-1:0] c_v,
		input logic [len_w-1:0] n_v, input logic intrude, input logic probe);
		int                cyc;
		logic [addr_w-1:0] ret_exp;
		@(negedge clk);
		start = 1'b1;
		m     = m_v;
		c     = c_v;
		n     = n_v;
		@(posedge clk);
		check_flag("busy", busy, 1'b0); // Engine is still idle at cycle 0.
		check_addr("return_val", return_val, last_ret);
		ref_fill(m_v, c_v, n_v);
		cyc = 0;
		while (cyc < int'(n_v) + 1)
		begin
			@(negedge clk);
			start     = 1'b0;
			rd_en     = 1'b0;
			rd_expect = 1'b0;
			if (intrude && cyc == 1)
			begin
				// A second command while busy must leave no trace.
				start = 1'b1;
				m     = m_v + addr_w'(7);
				c     = ~c_v;
				n     = len_w'(depth);
			end
			if (probe && cyc == 1)
			begin
				rd_en   = 1'b1; // Collides with the write of cycle 2.
				rd_addr = m_v;
			end
			@(posedge clk);
			cyc++;
			ret_exp = (cyc == int'(n_v) + 1) ? m_v : last_ret;
			check_flag("busy", busy, 1'b1);
			check_flag("finish", finish, cyc == int'(n_v) + 1);
			check_addr("return_val", return_val, ret_exp);
		end
		@(negedge clk);
		start    = 1'b0;
		rd_en    = 1'b0;
		last_ret = m_v;
		@(posedge clk);
		check_flag("busy", busy, 1'b0);
		check_flag("finish", finish, 1'b0);
		check_addr("return_val", return_val, last_ret);
	endtask

	// Back-to-back reads of the whole RAM.
	task read_back();
		for (int a = 0; a < depth; a++)
		begin
			@(negedge clk);
			rd_en     = 1'b1;
			rd_addr   = addr_w'(a);
			rd_expect = 1'b1;
			exp_q.push_back(ref_read(addr_w'(a)));
		end
		@(negedge clk);
		rd_en     = 1'b0;
		rd_expect = 1'b0;
		while (exp_q.size() != 0)
		begin
			@(negedge clk);
		end
	endtask

	initial
	begin : stimulus
		logic [addr_w-1:0] rm;
		logic [data_w-1:0] rc;
		logic [len_w-1:0]  rn;
		start   = 1'b0;
		m       = '0;
		c       = '0;
		n       = '0;
		rd_en   = 1'b0;
		rd_addr = '0;
		@(negedge reset);

		// Known full fill followed by a random one that wraps past the top.
		run_fill('0, 8'ha5, len_w'(depth), 1'b0, 1'b0);
		read_back();
		rm = addr_w'(16 + next_random() % 16);
		rc = data_w'(next_random());
		rn = len_w'(20 + next_random() % 13);
		run_fill(rm, rc, rn, 1'b0, 1'b0);
		read_back();

		// Zero length leaves the RAM alone.
		rm = addr_w'(next_random() % depth);
		rc = data_w'(next_random());
		run_fill(rm, rc, '0, 1'b0, 1'b0);
		read_back();

		// Start while busy.
		rm = addr_w'(next_random() % depth);
		rc = data_w'(next_random());
		rn = len_w'(4 + next_random() % 20);
		run_fill(rm, rc, rn, 1'b1, 1'b0);
		read_back();

		// Read against a fill write.
		rm = addr_w'(next_random() % depth);
		rc = data_w'(next_random());
		run_fill(rm, rc, len_w'(8), 1'b0, 1'b1);
		read_back();

		repeat (20)
		begin
			rm = addr_w'(next_random() % depth);
			rc = data_w'(next_random());
			rn = len_w'(next_random() % (depth + 1));
			run_fill(rm, rc, rn, 1'b0, 1'b0);
			read_back();
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

	initial
	begin
		#(watchdog_ns);
		abort_run($sformatf("run timed out after %0d ns without finishing", watchdog_ns));
	end

endmodule
